// File: Makefile
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_rvc_expander -Mdir obj_dir -f flist.f

run: compile
	./obj_dir/Vtb_rvc_expander | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
verilog/rvc_pkg.sv
verilog/rvc_quadrant0.sv
verilog/rvc_quadrant1.sv
verilog/rvc_quadrant2.sv
verilog/rvc_expander.sv
verif/rvc_expander_sva.sv
verif/rvc_checker.sv
verif/tb_rvc_expander.sv

// File: verif/rvc_checker.sv
/* watches the expander ports and compares each result with the
   expectation captured when its word was sampled */

`timescale 1ns/100ps

module rvc_checker (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 valid_i,
  input  logic [31:0]          instr_i,
  input  rvc_pkg::rvc_result_t exp_i,
  input  logic                 valid_o,
  input  rvc_pkg::rvc_result_t result_o,
  output int                   mismatch_cnt_o,
  output int                   protocol_cnt_o,
  output int                   check_cnt_o,
  output int                   pending_o
);

  // expectations for words in flight, oldest first
  rvc_pkg::rvc_result_t exp_q[$];
  logic [31:0]          word_q[$];

  initial begin
    mismatch_cnt_o = 0;
    protocol_cnt_o = 0;
    check_cnt_o    = 0;
    pending_o      = 0;
  end

  always @(posedge clk_i) begin
    rvc_pkg::rvc_result_t exp;
    logic [31:0]          word;
    if (!arst_n_i) begin
      exp_q.delete();
      word_q.delete();
      if (valid_o === 1'b1) begin
        $display("error at %0t: valid_o is high while reset is asserted", $time);
        protocol_cnt_o++;
      end
    end else begin
      if (valid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("error at %0t: valid_o is high with no word in flight", $time);
          protocol_cnt_o++;
        end else begin
          exp  = exp_q.pop_front();
          word = word_q.pop_front();
          check_cnt_o++;
          if (result_o !== exp) begin
            $display("mismatch at %0t: word %h expected instr %h ill %b cmp %b, got %h %b %b",
                     $time, word, exp.instr, exp.illegal, exp.compressed,
                     result_o.instr, result_o.illegal, result_o.compressed);
            mismatch_cnt_o++;
          end
        end
      end else if (exp_q.size() != 0) begin
        $display("error at %0t: valid_o stayed low one cycle after word %h", $time, word_q[0]);
        protocol_cnt_o++;
        exp_q.delete();
        word_q.delete();
      end
      // capture the expectation of the word sampled at this edge
      if (valid_i === 1'b1) begin
        exp_q.push_back(exp_i);
        word_q.push_back(instr_i);
      end
    end
    pending_o = exp_q.size();
  end

endmodule

// File: verif/rvc_expander_sva.sv
/* bound assertions for the expander: valid timing, reset state and
   pass-through of illegal or full-width words */

`timescale 1ns/100ps

module rvc_expander_sva (
  input logic                 clk_i,
  input logic                 arst_n_i,
  input logic                 valid_i,
  input logic [31:0]          instr_i,
  input logic                 valid_o,
  input rvc_pkg::rvc_result_t result_o
);

  // one-cycle latency from valid_i to valid_o
  a_valid_follow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i |=> valid_o) else $error("valid_o missing one cycle after valid_i");

  a_idle_follow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !valid_i |=> !valid_o) else $error("valid_o high one cycle after an idle cycle");

  a_reset_low: assert property (@(posedge clk_i)
    !arst_n_i |-> !valid_o) else $error("valid_o high during reset");

  // illegal and full-width results carry the fetched word unchanged
  a_pass_word: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i |=> (!(result_o.illegal || !result_o.compressed) ||
                 (result_o.instr == $past(instr_i))))
    else $error("illegal or full-width result differs from the fetched word");

endmodule

bind rvc_expander rvc_expander_sva u_sva (.*);

// File: verif/tb_rvc_expander.sv
/* testbench for the RV32C expander. runs a hand-written table of
   compressed words, then random full-width words, and prints a verdict */

`timescale 1ns/100ps

module tb_rvc_expander;

  typedef struct packed {
    logic [31:0] word;
    logic [31:0] instr;
    logic        illegal;
    logic        gap;
  } vec_t;

  logic                 clk;
  logic                 arst_n_i;
  logic                 valid_i;
  logic [31:0]          instr_i;
  logic                 valid_o;
  rvc_pkg::rvc_result_t result_o;
  rvc_pkg::rvc_result_t exp_r;

  int   mismatch_cnt;
  int   protocol_cnt;
  int   check_cnt;
  int   pending;
  int   cycle_cnt;
  int   cycle_limit;
  vec_t vecs[$];

  rvc_expander uut (
    .clk_i   (clk),
    .arst_n_i(arst_n_i),
    .valid_i (valid_i),
    .instr_i (instr_i),
    .valid_o (valid_o),
    .result_o(result_o)
  );

  rvc_checker u_checker (
    .clk_i         (clk),
    .arst_n_i      (arst_n_i),
    .valid_i       (valid_i),
    .instr_i       (instr_i),
    .exp_i         (exp_r),
    .valid_o       (valid_o),
    .result_o      (result_o),
    .mismatch_cnt_o(mismatch_cnt),
    .protocol_cnt_o(protocol_cnt),
    .check_cnt_o   (check_cnt),
    .pending_o     (pending)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // run limit, table plus random words plus margin
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic add_vec(input logic [31:0] word, input logic [31:0] instr,
                         input logic illegal, input logic gap);
    vecs.push_back('{word: word, instr: instr, illegal: illegal, gap: gap});
  endtask

  // drives one word a little after the rising edge, with its expectation
  task automatic apply_word(input logic valid, input logic [31:0] word,
                            input logic [31:0] instr, input logic illegal);
    @(posedge clk);
    #1;
    valid_i            = valid;
    instr_i            = word;
    exp_r.instr        = instr;
    exp_r.illegal      = illegal;
    exp_r.compressed   = (word[1:0] != 2'b11);
  endtask

  task automatic build_table;
    // quadrant 0
    add_vec(32'h0000_0040, 32'h0041_0413, 1'b0, 1'b0); // addi4spn x8, 4
    add_vec(32'h0000_0004, 32'h0000_0004, 1'b1, 1'b0); // addi4spn zero imm
    add_vec(32'h0000_4144, 32'h0045_2483, 1'b0, 1'b0); // lw x9, 4(x10)
    add_vec(32'h0000_C60C, 32'h00B6_2423, 1'b0, 1'b1); // sw x11, 8(x12)
    add_vec(32'h0000_2000, 32'h0000_2000, 1'b1, 1'b0); // fld
    add_vec(32'h0000_8000, 32'h0000_8000, 1'b1, 1'b0); // Zcb slot
    // quadrant 1
    add_vec(32'h0000_157D, 32'hFFF5_0513, 1'b0, 1'b0); // addi x10, -1
    add_vec(32'hBEEF_0001, 32'h0000_0013, 1'b0, 1'b0); // nop, upper half ignored
    add_vec(32'h0000_428D, 32'h0030_0293, 1'b0, 1'b0); // li x5, 3
    add_vec(32'h0000_6785, 32'h0000_17B7, 1'b0, 1'b0); // lui x15, 1
    add_vec(32'h0000_77FD, 32'hFFFF_F7B7, 1'b0, 1'b0); // lui x15, -1
    add_vec(32'h0000_717D, 32'hFF01_0113, 1'b0, 1'b0); // addi16sp -16
    add_vec(32'h0000_6781, 32'h0000_6781, 1'b1, 1'b1); // lui zero imm
    add_vec(32'h0000_8009, 32'h0024_5413, 1'b0, 1'b0); // srli x8, 2
    add_vec(32'h0000_848D, 32'h4034_D493, 1'b0, 1'b0); // srai x9, 3
    add_vec(32'h0000_9979, 32'hFFE5_7513, 1'b0, 1'b0); // andi x10, -2
    add_vec(32'h0000_8C05, 32'h4094_0433, 1'b0, 1'b0); // sub x8, x9
    add_vec(32'h0000_8DB1, 32'h00C5_C5B3, 1'b0, 1'b0); // xor x11, x12
    add_vec(32'h0000_8ED9, 32'h00E6_E6B3, 1'b0, 1'b0); // or x13, x14
    add_vec(32'h0000_8FE1, 32'h0087_F7B3, 1'b0, 1'b0); // and x15, x8
    add_vec(32'h0000_9C05, 32'h0000_9C05, 1'b1, 1'b0); // subw, bit 12 set
    add_vec(32'h0000_BFFD, 32'hFFFF_F06F, 1'b0, 1'b0); // j -2
    add_vec(32'h0000_2021, 32'h0080_00EF, 1'b0, 1'b0); // jal +8
    add_vec(32'h0000_A845, 32'h0B00_006F, 1'b0, 1'b0); // j +0xb0
    add_vec(32'h0000_C401, 32'h0004_0463, 1'b0, 1'b0); // beqz x8, +8
    add_vec(32'h0000_FCF5, 32'hFE04_9EE3, 1'b0, 1'b1); // bnez x9, -4
    // quadrant 2
    add_vec(32'h0000_0512, 32'h0045_1513, 1'b0, 1'b0); // slli x10, 4
    add_vec(32'h0000_40B2, 32'h00C1_2083, 1'b0, 1'b0); // lwsp x1, 12
    add_vec(32'h0000_4032, 32'h0000_4032, 1'b1, 1'b0); // lwsp rd 0
    add_vec(32'h0000_C822, 32'h0081_2823, 1'b0, 1'b0); // swsp x8, 16
    add_vec(32'h0000_8082, 32'h0000_8067, 1'b0, 1'b0); // jr x1
    add_vec(32'hDEAD_8002, 32'hDEAD_8002, 1'b1, 1'b0); // jr x0
    add_vec(32'h0000_852E, 32'h00B0_0533, 1'b0, 1'b0); // mv x10, x11
    add_vec(32'h0000_9002, 32'h0010_0073, 1'b0, 1'b0); // ebreak
    add_vec(32'h0000_9282, 32'h0002_80E7, 1'b0, 1'b0); // jalr x5
    add_vec(32'h0000_931E, 32'h0073_0333, 1'b0, 1'b0); // add x6, x7
    add_vec(32'h0000_6002, 32'h0000_6002, 1'b1, 1'b0); // flwsp
    add_vec(32'h00A5_0533, 32'h00A5_0533, 1'b0, 1'b0); // full-width add
  endtask

  initial begin
    logic [31:0] rnd;
    cycle_cnt   = 0;
    cycle_limit = 1000;
    arst_n_i    = 1'b0;
    valid_i     = 1'b0;
    instr_i     = '0;
    exp_r       = '0;
    void'($urandom(32'h30df_2b46));
    build_table();
    cycle_limit = vecs.size() + 40 + 20;

    repeat (2) @(posedge clk);
    #1;
    arst_n_i = 1'b1;

    foreach (vecs[i]) begin
      apply_word(1'b1, vecs[i].word, vecs[i].instr, vecs[i].illegal);
      if (vecs[i].gap) begin
        apply_word(1'b0, '0, '0, 1'b0);
      end
    end

    // ----------------------------------------
    // random full-width words
    // ----------------------------------------
    for (int n = 0; n < 40; n++) begin
      rnd      = $urandom;
      rnd[1:0] = 2'b11;
      apply_word(1'b1, rnd, rnd, 1'b0);
    end
    apply_word(1'b0, '0, '0, 1'b0);

    while (pending != 0) begin
      @(posedge clk);
    end
    @(posedge clk);

    $display("checks=%0d mismatches=%0d protocol_errors=%0d",
             check_cnt, mismatch_cnt, protocol_cnt);
    if (mismatch_cnt == 0 && protocol_cnt == 0 && check_cnt == vecs.size() + 40) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: verilog/rvc_expander.sv
/* RV32C expander top level. one word per cycle in on valid_i,
   expanded result registered and presented one cycle later */

`timescale 1ns/100ps

module rvc_expander (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 valid_i,
  input  logic [31:0]          instr_i,
  output logic                 valid_o,
  output rvc_pkg::rvc_result_t result_o
);

  rvc_pkg::rvc_half_t   half;
  rvc_pkg::expand_t     exp_q0;
  rvc_pkg::expand_t     exp_q1;
  rvc_pkg::expand_t     exp_q2;
  rvc_pkg::expand_t     exp_sel;
  rvc_pkg::rvc_result_t result_d;

  assign half = instr_i[15:0];

  // ----------------------------------------
  // quadrant decoders, all in parallel
  // ----------------------------------------
  rvc_quadrant0 u_quad0 (.half_i(half), .exp_o(exp_q0));
  rvc_quadrant1 u_quad1 (.half_i(half), .exp_o(exp_q1));
  rvc_quadrant2 u_quad2 (.half_i(half), .exp_o(exp_q2));

  // quadrant select, 2'b11 is a full-width word and goes through untouched
  always_comb begin
    case (instr_i[1:0])
      rvc_pkg::QUAD_C0: exp_sel = exp_q0;
      rvc_pkg::QUAD_C1: exp_sel = exp_q1;
      rvc_pkg::QUAD_C2: exp_sel = exp_q2;
      default: begin
        exp_sel.instr   = instr_i;
        exp_sel.illegal = 1'b0;
      end
    endcase
  end

  // illegal words are handed on as fetched
  assign result_d.instr      = exp_sel.illegal ? instr_i : exp_sel.instr;
  assign result_d.illegal    = exp_sel.illegal;
  assign result_d.compressed = (instr_i[1:0] != 2'b11);

  // ----------------------------------------
  // output stage
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= valid_i;
      // result holds over idle cycles
      if (valid_i) begin
        result_o <= result_d;
      end
    end
  end

endmodule

// File: verilog/rvc_pkg.sv
/* shared constants and types for the RV32C expander.
   quadrant modules and the top level refer to these by scoped name */

package rvc_pkg;

  // ----------------------------------------
  // 32-bit major opcodes
  // ----------------------------------------
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // low two bits of a compressed word, 2'b11 means a full-width word
  localparam logic [1:0] QUAD_C0 = 2'b00;
  localparam logic [1:0] QUAD_C1 = 2'b01;
  localparam logic [1:0] QUAD_C2 = 2'b10;

  // ----------------------------------------
  // compressed funct3 codes, bits 15:13
  // ----------------------------------------
  localparam logic [2:0] C0_ADDI4SPN = 3'b000;
  localparam logic [2:0] C0_LW       = 3'b010;
  localparam logic [2:0] C0_SW       = 3'b110;

  localparam logic [2:0] C1_ADDI         = 3'b000;
  localparam logic [2:0] C1_JAL          = 3'b001;
  localparam logic [2:0] C1_LI           = 3'b010;
  localparam logic [2:0] C1_LUI_ADDI16SP = 3'b011;
  localparam logic [2:0] C1_MISC_ALU     = 3'b100;
  localparam logic [2:0] C1_J            = 3'b101;
  localparam logic [2:0] C1_BEQZ         = 3'b110;
  localparam logic [2:0] C1_BNEZ         = 3'b111;

  localparam logic [2:0] C2_SLLI      = 3'b000;
  localparam logic [2:0] C2_LWSP      = 3'b010;
  localparam logic [2:0] C2_JR_MV_ADD = 3'b100;
  localparam logic [2:0] C2_SWSP      = 3'b110;

  // architectural registers with a fixed role in the expansions
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef logic [15:0] rvc_half_t;

  // per-quadrant expansion result
  typedef struct packed {
    logic [31:0] instr;
    logic        illegal;
  } expand_t;

  // registered result of the top level
  typedef struct packed {
    logic [31:0] instr;
    logic        illegal;
    logic        compressed;
  } rvc_result_t;

endpackage

// File: verilog/rvc_quadrant0.sv
/* quadrant 0 expansion: c.addi4spn, c.lw and c.sw, combinational.
   all other funct3 codes of this quadrant report illegal */

`timescale 1ns/100ps

module rvc_quadrant0 (
  input  rvc_pkg::rvc_half_t half_i,
  output rvc_pkg::expand_t   exp_o
);

  logic [2:0] funct3;
  // rd'/rs2' and rs1' widened to x8..x15
  logic [4:0] reg_p_lo;
  logic [4:0] reg_p_hi;

  assign funct3   = half_i[15:13];
  assign reg_p_lo = {2'b01, half_i[4:2]};
  assign reg_p_hi = {2'b01, half_i[9:7]};

  always_comb begin
    exp_o.instr   = '0;
    exp_o.illegal = 1'b0;

    case (funct3)
      rvc_pkg::C0_ADDI4SPN: begin
        // addi rd', sp, nzuimm[9:2]
        exp_o.instr = {2'b00, half_i[10:7], half_i[12:11], half_i[5], half_i[6], 2'b00,
                       rvc_pkg::REG_SP, 3'b000, reg_p_lo, rvc_pkg::OPC_OP_IMM};
        // zero immediate is the reserved all-zero encoding
        exp_o.illegal = (half_i[12:5] == 8'h00);
      end

      rvc_pkg::C0_LW: begin
        // lw rd', uimm[6:2](rs1')
        exp_o.instr = {5'b00000, half_i[5], half_i[12:10], half_i[6], 2'b00,
                       reg_p_hi, 3'b010, reg_p_lo, rvc_pkg::OPC_LOAD};
      end

      rvc_pkg::C0_SW: begin
        // sw rs2', uimm[6:2](rs1')
        exp_o.instr = {5'b00000, half_i[5], half_i[12], reg_p_lo, reg_p_hi, 3'b010,
                       half_i[11:10], half_i[6], 2'b00, rvc_pkg::OPC_STORE};
      end

      // fld/flw/fsd/fsw, Zcb slot and reserved
      default: begin
        exp_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/rvc_quadrant1.sv
/* quadrant 1 expansion: immediates, misc ALU, jumps and branches.
   purely combinational, the top level picks the result by quadrant */

`timescale 1ns/100ps

module rvc_quadrant1 (
  input  rvc_pkg::rvc_half_t half_i,
  output rvc_pkg::expand_t   exp_o
);

  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic [4:0]  rd_p;
  logic [4:0]  rs2_p;
  // sign-extended 6-bit CI immediate
  logic [11:0] imm_ci;
  // addi16sp immediate, already in units of bytes
  logic [11:0] imm_16sp;
  // jal imm[20|10:1|11|19:12] as laid out in the 32-bit word
  logic [19:0] j_field;
  // branch imm[12|10:5] and imm[4:1|11]
  logic [6:0]  b_hi;
  logic [4:0]  b_lo;
  logic [6:0]  alu_funct7;
  logic [2:0]  alu_funct3;

  assign funct3 = half_i[15:13];
  assign rd     = half_i[11:7];
  assign rd_p   = {2'b01, half_i[9:7]};
  assign rs2_p  = {2'b01, half_i[4:2]};

  assign imm_ci   = {{6{half_i[12]}}, half_i[12], half_i[6:2]};
  assign imm_16sp = {{3{half_i[12]}}, half_i[4:3], half_i[5], half_i[2], half_i[6], 4'b0000};

  // offset scramble of the CJ format
  assign j_field = {half_i[12], half_i[8], half_i[10:9], half_i[6], half_i[7], half_i[2],
                    half_i[11], half_i[5:3], {9{half_i[12]}}};

  // offset scramble of the CB format
  assign b_hi = {{4{half_i[12]}}, half_i[6:5], half_i[2]};
  assign b_lo = {half_i[11:10], half_i[4:3], half_i[12]};

  // register-register group of misc ALU, selected by bits 6:5
  always_comb begin
    case (half_i[6:5])
      2'b00: begin
        alu_funct7 = 7'b0100000;
        alu_funct3 = 3'b000;
      end
      2'b01: begin
        alu_funct7 = 7'b0000000;
        alu_funct3 = 3'b100;
      end
      2'b10: begin
        alu_funct7 = 7'b0000000;
        alu_funct3 = 3'b110;
      end
      default: begin
        alu_funct7 = 7'b0000000;
        alu_funct3 = 3'b111;
      end
    endcase
  end

  always_comb begin
    exp_o.instr   = '0;
    exp_o.illegal = 1'b0;

    case (funct3)
      rvc_pkg::C1_ADDI: begin
        // c.nop is the rd = 0 case and needs no special path
        exp_o.instr = {imm_ci, rd, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
      end

      rvc_pkg::C1_JAL: begin
        exp_o.instr = {j_field, rvc_pkg::REG_RA, rvc_pkg::OPC_JAL};
      end

      rvc_pkg::C1_LI: begin
        exp_o.instr = {imm_ci, rvc_pkg::REG_ZERO, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
      end

      rvc_pkg::C1_LUI_ADDI16SP: begin
        if (rd == rvc_pkg::REG_SP) begin
          exp_o.instr = {imm_16sp, rvc_pkg::REG_SP, 3'b000, rvc_pkg::REG_SP,
                         rvc_pkg::OPC_OP_IMM};
        end else begin
          exp_o.instr = {{15{half_i[12]}}, half_i[6:2], rd, rvc_pkg::OPC_LUI};
        end
        exp_o.illegal = ({half_i[12], half_i[6:2]} == 6'b000000);
      end

      rvc_pkg::C1_MISC_ALU: begin
        case (half_i[11:10])
          2'b00, 2'b01: begin
            // srli / srai, bit 10 picks the arithmetic form
            exp_o.instr = {1'b0, half_i[10], 4'b0000, half_i[12], half_i[6:2], rd_p,
                           3'b101, rd_p, rvc_pkg::OPC_OP_IMM};
          end
          2'b10: begin
            exp_o.instr = {imm_ci, rd_p, 3'b111, rd_p, rvc_pkg::OPC_OP_IMM};
          end
          default: begin
            exp_o.instr   = {alu_funct7, rs2_p, rd_p, alu_funct3, rd_p, rvc_pkg::OPC_OP};
            // subw/addw and the Zcb ops live here
            exp_o.illegal = half_i[12];
          end
        endcase
      end

      rvc_pkg::C1_J: begin
        exp_o.instr = {j_field, rvc_pkg::REG_ZERO, rvc_pkg::OPC_JAL};
      end

      // beqz and bnez differ only in funct3 bit 0
      default: begin
        exp_o.instr = {b_hi, rvc_pkg::REG_ZERO, rd_p, 2'b00, funct3 == rvc_pkg::C1_BNEZ,
                       b_lo, rvc_pkg::OPC_BRANCH};
      end
    endcase
  end

endmodule

// File: verilog/rvc_quadrant2.sv
/* quadrant 2 expansion: slli, sp-relative load and store, and the
   jr/mv/ebreak/jalr/add group, combinational */

`timescale 1ns/100ps

module rvc_quadrant2 (
  input  rvc_pkg::rvc_half_t half_i,
  output rvc_pkg::expand_t   exp_o
);

  logic [2:0] funct3;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic       rs1_zero;
  logic       rs2_zero;

  // rd and rs1 share bits 11:7 in the CR and CI formats
  assign funct3   = half_i[15:13];
  assign rs1      = half_i[11:7];
  assign rs2      = half_i[6:2];
  assign rs1_zero = (rs1 == rvc_pkg::REG_ZERO);
  assign rs2_zero = (rs2 == rvc_pkg::REG_ZERO);

  always_comb begin
    exp_o.instr   = '0;
    exp_o.illegal = 1'b0;

    case (funct3)
      rvc_pkg::C2_SLLI: begin
        exp_o.instr = {6'b000000, half_i[12], rs2, rs1, 3'b001, rs1, rvc_pkg::OPC_OP_IMM};
      end

      rvc_pkg::C2_LWSP: begin
        // lw rd, uimm[7:2](sp)
        exp_o.instr   = {4'b0000, half_i[3:2], half_i[12], half_i[6:4], 2'b00,
                         rvc_pkg::REG_SP, 3'b010, rs1, rvc_pkg::OPC_LOAD};
        exp_o.illegal = rs1_zero;
      end

      rvc_pkg::C2_JR_MV_ADD: begin
        if (!half_i[12]) begin
          if (rs2_zero) begin
            // c.jr, rs1 = 0 is reserved
            exp_o.instr   = {12'h000, rs1, 3'b000, rvc_pkg::REG_ZERO, rvc_pkg::OPC_JALR};
            exp_o.illegal = rs1_zero;
          end else begin
            // c.mv
            exp_o.instr = {7'b0000000, rs2, rvc_pkg::REG_ZERO, 3'b000, rs1, rvc_pkg::OPC_OP};
          end
        end else if (rs2_zero && rs1_zero) begin
          exp_o.instr = rvc_pkg::EBREAK_WORD;
        end else if (rs2_zero) begin
          // c.jalr links through ra
          exp_o.instr = {12'h000, rs1, 3'b000, rvc_pkg::REG_RA, rvc_pkg::OPC_JALR};
        end else begin
          exp_o.instr = {7'b0000000, rs2, rs1, 3'b000, rs1, rvc_pkg::OPC_OP};
        end
      end

      rvc_pkg::C2_SWSP: begin
        // sw rs2, uimm[7:2](sp)
        exp_o.instr = {4'b0000, half_i[8:7], half_i[12], rs2, rvc_pkg::REG_SP, 3'b010,
                       half_i[11:9], 2'b00, rvc_pkg::OPC_STORE};
      end

      // fldsp/flwsp/fsdsp/fswsp
      default: begin
        exp_o.illegal = 1'b1;
      end
    endcase
  end

endmodule
